// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - hw/decode_pkg.sv
      - hw/instr_decoder.sv
      - hw/reg_file.sv
      - hw/operand_select.sv
      - hw/decode_pipe_reg.sv
      - hw/decode_stage.sv
  - target: test
    files:
      - tests/tb_decode_stage.sv

// ==== decode_stage.f ====
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/operand_select.sv
hw/decode_pipe_reg.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

// ==== hw/decode_pipe_reg.sv ====
// Decode to execute stage register with stall, flush and asynchronous reset
`timescale 1ns/10ps
`default_nettype none

module decode_pipe_reg (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     stall_i,
    input  wire logic                     flush_i,
    input  wire decode_pkg::alu_op_e      alu_op_i,
    input  wire decode_pkg::instr_class_e class_i,
    input  wire decode_pkg::funct3_t      funct3_i,
    input  wire decode_pkg::reg_addr_t    rd_addr_i,
    input  wire decode_pkg::word_t        op1_i,
    input  wire decode_pkg::word_t        op2_i,
    input  wire logic                     lt_i,
    input  wire logic                     ltu_i,
    input  wire logic                     eq_i,
    input  wire decode_pkg::pc_t          pc_i,
    input  wire logic                     illegal_i,
    output decode_pkg::alu_op_e           exe_alu_op_o,
    output decode_pkg::instr_class_e      exe_class_o,
    output decode_pkg::funct3_t           exe_funct3_o,
    output decode_pkg::reg_addr_t         exe_rd_addr_o,
    output decode_pkg::word_t             exe_op1_o,
    output decode_pkg::word_t             exe_op2_o,
    output logic                          exe_lt_o,
    output logic                          exe_ltu_o,
    output logic                          exe_eq_o,
    output decode_pkg::pc_t               exe_pc_o,
    output logic                          exe_illegal_o
);

    import decode_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exe_alu_op_o  <= alu_add;
            exe_class_o   <= cls_none;
            exe_funct3_o  <= '0;
            exe_rd_addr_o <= '0;
            exe_op1_o     <= '0;
            exe_op2_o     <= '0;
            exe_lt_o      <= 1'b0;
            exe_ltu_o     <= 1'b0;
            exe_eq_o      <= 1'b0;
            exe_pc_o      <= '0;
            exe_illegal_o <= 1'b0;
        end else if (flush_i) begin  // Flush wins over stall
            exe_alu_op_o  <= alu_add;
            exe_class_o   <= cls_none;
            exe_funct3_o  <= '0;
            exe_rd_addr_o <= '0;
            exe_op1_o     <= '0;
            exe_op2_o     <= '0;
            exe_lt_o      <= 1'b0;
            exe_ltu_o     <= 1'b0;
            exe_eq_o      <= 1'b0;
            exe_pc_o      <= '0;
            exe_illegal_o <= 1'b0;
        end else if (!stall_i) begin
            exe_alu_op_o  <= alu_op_i;
            exe_class_o   <= class_i;
            exe_funct3_o  <= funct3_i;
            exe_rd_addr_o <= rd_addr_i;
            exe_op1_o     <= op1_i;
            exe_op2_o     <= op2_i;
            exe_lt_o      <= lt_i;
            exe_ltu_o     <= ltu_i;
            exe_eq_o      <= eq_i;
            exe_pc_o      <= pc_i;
            exe_illegal_o <= illegal_i;
        end
    end

    flush_bubble_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flush_i |=> exe_class_o == cls_none && !exe_illegal_o);

    stall_holds_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_i && !flush_i |=> $stable({exe_alu_op_o, exe_class_o, exe_funct3_o,
            exe_rd_addr_o, exe_op1_o, exe_op2_o, exe_lt_o, exe_ltu_o, exe_eq_o,
            exe_pc_o, exe_illegal_o}));

endmodule

`default_nettype wire

// ==== hw/decode_pkg.sv ====
// Decode stage widths, vector types, control enums and RV32I opcode constants
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;  // Data path width
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;  // x0 included

    typedef logic [xlen-1:0]       word_t;
    typedef logic [31:0]           instr_t;  // Fixed by the ISA, not by xlen
    typedef logic [xlen-1:0]       pc_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [2:0]            funct3_t;

    // Operation handed to the execute ALU
    typedef enum logic [3:0] {
        alu_add  = 4'd0,  // Also address and target arithmetic
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        cls_none   = 4'd0,  // Bubble or illegal encoding
        cls_alu    = 4'd1,
        cls_load   = 4'd2,
        cls_store  = 4'd3,
        cls_branch = 4'd4,
        cls_jal    = 4'd5,
        cls_jalr   = 4'd6,
        cls_lui    = 4'd7,
        cls_auipc  = 4'd8
    } instr_class_e;

    typedef enum logic [2:0] {
        fmt_r = 3'd0,  // No immediate
        fmt_i = 3'd1,
        fmt_s = 3'd2,
        fmt_b = 3'd3,
        fmt_u = 3'd4,
        fmt_j = 3'd5
    } imm_fmt_e;

    // Forwarding source chosen by the hazard unit
    typedef enum logic [1:0] {
        fwd_none = 2'd0,  // Register file value
        fwd_exe  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

    // Major opcodes, instruction bits [6:2]
    localparam logic [4:0] opc_load   = 5'b00000;
    localparam logic [4:0] opc_store  = 5'b01000;
    localparam logic [4:0] opc_op     = 5'b01100;
    localparam logic [4:0] opc_op_imm = 5'b00100;
    localparam logic [4:0] opc_branch = 5'b11000;
    localparam logic [4:0] opc_jal    = 5'b11011;
    localparam logic [4:0] opc_jalr   = 5'b11001;
    localparam logic [4:0] opc_lui    = 5'b01101;
    localparam logic [4:0] opc_auipc  = 5'b00101;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
// Decode and register read stage top level with decoder, register file and stage register
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire decode_pkg::instr_t    instr_i,      // From fetch
    input  wire decode_pkg::pc_t       pc_i,
    input  wire logic                  stall_i,      // From hazard unit
    input  wire logic                  flush_i,
    input  wire decode_pkg::fwd_sel_e  fwd_sel1_i,
    input  wire decode_pkg::fwd_sel_e  fwd_sel2_i,
    input  wire decode_pkg::word_t     exe_fwd_data_i,
    input  wire decode_pkg::reg_addr_t wb_addr_i,    // Writeback port
    input  wire decode_pkg::word_t     wb_data_i,
    input  wire logic                  wb_we_i,
    output decode_pkg::reg_addr_t      rs1_addr_o,   // To hazard unit
    output decode_pkg::reg_addr_t      rs2_addr_o,
    output decode_pkg::alu_op_e        exe_alu_op_o,
    output decode_pkg::instr_class_e   exe_class_o,
    output decode_pkg::funct3_t        exe_funct3_o,
    output decode_pkg::reg_addr_t      exe_rd_addr_o,
    output decode_pkg::word_t          exe_op1_o,
    output decode_pkg::word_t          exe_op2_o,
    output logic                       exe_lt_o,
    output logic                       exe_ltu_o,
    output logic                       exe_eq_o,
    output decode_pkg::pc_t            exe_pc_o,
    output logic                       exe_illegal_o
);

    import decode_pkg::*;

    alu_op_e      alu_op;
    instr_class_e instr_class;
    funct3_t      funct3;
    reg_addr_t    rd_addr;
    logic         op1_is_pc;
    logic         op2_is_imm;
    word_t        imm;
    logic         illegal;
    word_t        rs1_data;
    word_t        rs2_data;
    word_t        op1;
    word_t        op2;
    logic         lt;
    logic         ltu;
    logic         eq;

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr    = instr_i[11:7];   // Passed on even for stores and branches
    assign funct3     = instr_i[14:12];  // Load/store width and branch condition

    instr_decoder i_instr_decoder (
        .instr_i      (instr_i),
        .alu_op_o     (alu_op),
        .class_o      (instr_class),
        .op1_is_pc_o  (op1_is_pc),
        .op2_is_imm_o (op2_is_imm),
        .imm_o        (imm),
        .illegal_o    (illegal)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd_addr1_i (rs1_addr_o),
        .rd_addr2_i (rs2_addr_o),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_we_i),
        .rd_data1_o (rs1_data),
        .rd_data2_o (rs2_data)
    );

    operand_select i_operand_select (
        .fwd_sel1_i   (fwd_sel1_i),
        .fwd_sel2_i   (fwd_sel2_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .exe_data_i   (exe_fwd_data_i),
        .wb_data_i    (wb_data_i),
        .pc_i         (pc_i),
        .imm_i        (imm),
        .op1_is_pc_i  (op1_is_pc),
        .op2_is_imm_i (op2_is_imm),
        .op1_o        (op1),
        .op2_o        (op2),
        .lt_o         (lt),
        .ltu_o        (ltu),
        .eq_o         (eq)
    );

    decode_pipe_reg i_decode_pipe_reg (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .alu_op_i      (alu_op),
        .class_i       (instr_class),
        .funct3_i      (funct3),
        .rd_addr_i     (rd_addr),
        .op1_i         (op1),
        .op2_i         (op2),
        .lt_i          (lt),
        .ltu_i         (ltu),
        .eq_i          (eq),
        .pc_i          (pc_i),
        .illegal_i     (illegal),
        .exe_alu_op_o  (exe_alu_op_o),
        .exe_class_o   (exe_class_o),
        .exe_funct3_o  (exe_funct3_o),
        .exe_rd_addr_o (exe_rd_addr_o),
        .exe_op1_o     (exe_op1_o),
        .exe_op2_o     (exe_op2_o),
        .exe_lt_o      (exe_lt_o),
        .exe_ltu_o     (exe_ltu_o),
        .exe_eq_o      (exe_eq_o),
        .exe_pc_o      (exe_pc_o),
        .exe_illegal_o (exe_illegal_o)
    );

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
// RV32I instruction decoder for ALU op, class, operand selects and immediate
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  wire decode_pkg::instr_t  instr_i,
    output decode_pkg::alu_op_e      alu_op_o,
    output decode_pkg::instr_class_e class_o,
    output logic                     op1_is_pc_o,
    output logic                     op2_is_imm_o,
    output decode_pkg::word_t        imm_o,
    output logic                     illegal_o
);

    import decode_pkg::*;

    logic [4:0] opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    imm_fmt_e   fmt;
    logic       legal;
    alu_op_e    arith_op;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Bit 30 picks SUB only on register ops, on OP-IMM it is immediate data
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == opc_op && instr_i[30]) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = instr_i[30] ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        class_o      = cls_none;
        alu_op_o     = alu_add;  // Loads, stores, branches and jumps
        fmt          = fmt_r;
        op1_is_pc_o  = 1'b0;
        op2_is_imm_o = 1'b0;
        legal        = 1'b0;
        case (opcode)
            opc_op: begin
                class_o  = cls_alu;
                alu_op_o = arith_op;
                legal    = (funct7 == 7'h00) ||
                           (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            opc_op_imm: begin
                class_o      = cls_alu;
                alu_op_o     = arith_op;
                fmt          = fmt_i;
                op2_is_imm_o = 1'b1;
                case (funct3)
                    3'b001:  legal = (funct7 == 7'h00);  // SLLI
                    3'b101:  legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                    default: legal = 1'b1;
                endcase
            end
            opc_load: begin
                class_o      = cls_load;
                fmt          = fmt_i;
                op2_is_imm_o = 1'b1;
                legal        = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
            end
            opc_store: begin
                class_o      = cls_store;
                fmt          = fmt_s;
                op2_is_imm_o = 1'b1;
                legal        = !funct3[2] && (funct3[1:0] != 2'b11);  // SB, SH, SW
            end
            opc_branch: begin
                class_o      = cls_branch;
                fmt          = fmt_b;
                op1_is_pc_o  = 1'b1;  // ALU forms the target, flags decide
                op2_is_imm_o = 1'b1;
                legal        = (funct3[2:1] != 2'b01);
            end
            opc_jal: begin
                class_o      = cls_jal;
                fmt          = fmt_j;
                op1_is_pc_o  = 1'b1;
                op2_is_imm_o = 1'b1;
                legal        = 1'b1;
            end
            opc_jalr: begin
                class_o      = cls_jalr;
                fmt          = fmt_i;
                op2_is_imm_o = 1'b1;
                legal        = (funct3 == 3'b000);
            end
            opc_lui: begin
                class_o      = cls_lui;
                fmt          = fmt_u;
                op2_is_imm_o = 1'b1;
                legal        = 1'b1;
            end
            opc_auipc: begin
                class_o      = cls_auipc;
                fmt          = fmt_u;
                op1_is_pc_o  = 1'b1;
                op2_is_imm_o = 1'b1;
                legal        = 1'b1;
            end
            default: legal = 1'b0;  // SYSTEM, MISC-MEM and unused opcodes
        endcase
        if (instr_i[1:0] != 2'b11 || !legal) begin  // Compressed space is not supported
            legal        = 1'b0;
            class_o      = cls_none;
            alu_op_o     = alu_add;
            fmt          = fmt_r;
            op1_is_pc_o  = 1'b0;
            op2_is_imm_o = 1'b0;
        end
    end

    assign illegal_o = !legal;

    always_comb begin
        case (fmt)
            fmt_i:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            fmt_s:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            fmt_b:   imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            fmt_u:   imm_o = {instr_i[31:12], 12'b0};
            fmt_j:   imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

    legal_has_class_a: assert final (illegal_o || class_o != cls_none);

endmodule

`default_nettype wire

// ==== hw/operand_select.sv ====
// Forwarding muxes, operand selection and branch comparison flags
`timescale 1ns/10ps
`default_nettype none

module operand_select (
    input  wire decode_pkg::fwd_sel_e fwd_sel1_i,
    input  wire decode_pkg::fwd_sel_e fwd_sel2_i,
    input  wire decode_pkg::word_t    rs1_data_i,
    input  wire decode_pkg::word_t    rs2_data_i,
    input  wire decode_pkg::word_t    exe_data_i,
    input  wire decode_pkg::word_t    wb_data_i,
    input  wire decode_pkg::pc_t      pc_i,
    input  wire decode_pkg::word_t    imm_i,
    input  wire logic                 op1_is_pc_i,
    input  wire logic                 op2_is_imm_i,
    output decode_pkg::word_t         op1_o,
    output decode_pkg::word_t         op2_o,
    output logic                      lt_o,
    output logic                      ltu_o,
    output logic                      eq_o
);

    import decode_pkg::*;

    word_t rs1_fwd;
    word_t rs2_fwd;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t exe_val,
            word_t wb_val);
        case (sel)
            fwd_exe: return exe_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign rs1_fwd = fwd_mux(fwd_sel1_i, rs1_data_i, exe_data_i, wb_data_i);
    assign rs2_fwd = fwd_mux(fwd_sel2_i, rs2_data_i, exe_data_i, wb_data_i);

    assign op1_o = op1_is_pc_i ? pc_i : rs1_fwd;
    assign op2_o = op2_is_imm_i ? imm_i : rs2_fwd;

    // Flags see the register values even when PC or immediate is selected
    assign lt_o  = $signed(rs1_fwd) < $signed(rs2_fwd);
    assign ltu_o = rs1_fwd < rs2_fwd;
    assign eq_o  = rs1_fwd == rs2_fwd;

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
// Integer register file with two asynchronous reads and one synchronous write
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,
    input  wire decode_pkg::reg_addr_t rd_addr1_i,
    input  wire decode_pkg::reg_addr_t rd_addr2_i,
    input  wire decode_pkg::reg_addr_t wr_addr_i,
    input  wire decode_pkg::word_t     wr_data_i,
    input  wire logic                 wr_en_i,
    output decode_pkg::word_t         rd_data1_o,
    output decode_pkg::word_t         rd_data2_o
);

    import decode_pkg::*;

    word_t regs [num_regs];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data1_o = regs[rd_addr1_i];  // No write-through, forwarding covers it
    assign rd_data2_o = regs[rd_addr2_i];

    x0_reads_zero_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rd_addr1_i == '0 |-> rd_data1_o == '0) and
        (rd_addr2_i == '0 |-> rd_data2_o == '0));

endmodule

`default_nettype wire

// ==== tests/tb_decode_stage.sv ====
// Testbench for decode_stage with clock, reset, stimulus table, row loop and checks
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;

    import decode_pkg::*;

    localparam instr_t nop = 32'h0000_0013;  // ADDI x0, x0, 0

    typedef struct packed {
        instr_class_e cls;
        alu_op_e      op;
        reg_addr_t    rd;
        funct3_t      f3;
        word_t        op1;
        word_t        op2;
        logic         lt;
        logic         ltu;
        logic         eq;
        pc_t          pc;
        logic         illegal;
    } exp_t;

    typedef struct packed {
        logic [2:0] test;
        instr_t     instr;
        pc_t        pc;
        logic       stall;
        logic       flush;
        fwd_sel_e   fwd1;
        fwd_sel_e   fwd2;
        word_t      exe_data;
        reg_addr_t  wb_addr;
        word_t      wb_data;
        logic       wb_we;
        exp_t       exp;
    } row_t;

    logic         clk_i;
    logic         arst_n_i;
    instr_t       instr_i;
    pc_t          pc_i;
    logic         stall_i;
    logic         flush_i;
    fwd_sel_e     fwd_sel1_i;
    fwd_sel_e     fwd_sel2_i;
    word_t        exe_fwd_data_i;
    reg_addr_t    wb_addr_i;
    word_t        wb_data_i;
    logic         wb_we_i;
    reg_addr_t    rs1_addr_o;
    reg_addr_t    rs2_addr_o;
    alu_op_e      exe_alu_op_o;
    instr_class_e exe_class_o;
    funct3_t      exe_funct3_o;
    reg_addr_t    exe_rd_addr_o;
    word_t        exe_op1_o;
    word_t        exe_op2_o;
    logic         exe_lt_o;
    logic         exe_ltu_o;
    logic         exe_eq_o;
    pc_t          exe_pc_o;
    logic         exe_illegal_o;

    row_t        rows [64];
    int          n_rows;
    int          checks;
    int          errors [6];
    string       test_names [6];
    word_t       regs_model [num_regs];  // Expected register contents
    exp_t        last_exp;
    logic [31:0] lcg_state;

    // Inputs of the next table row, back to defaults after each row
    pc_t       nxt_pc;
    logic      nxt_stall;
    logic      nxt_flush;
    fwd_sel_e  nxt_fwd1;
    fwd_sel_e  nxt_fwd2;
    word_t     nxt_exe;
    reg_addr_t nxt_wb_addr;
    word_t     nxt_wb_data;
    logic      nxt_wb_we;

    decode_stage i_decode_stage (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
            funct3_t f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op, 2'b11};
    endfunction

    function automatic instr_t enc_i(word_t imm, reg_addr_t rs1, funct3_t f3, reg_addr_t rd,
            logic [4:0] opc);
        return {imm[11:0], rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic instr_t enc_s(word_t imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store, 2'b11};
    endfunction

    function automatic instr_t enc_b(word_t imm, reg_addr_t rs2, reg_addr_t rs1, funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch, 2'b11};
    endfunction

    function automatic instr_t enc_u(word_t imm, reg_addr_t rd, logic [4:0] opc);
        return {imm[31:12], rd, opc, 2'b11};
    endfunction

    function automatic instr_t enc_j(word_t imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal, 2'b11};
    endfunction

    function automatic word_t forwarded(fwd_sel_e sel, reg_addr_t addr);
        if (sel == fwd_exe) return nxt_exe;
        if (sel == fwd_wb) return nxt_wb_data;
        return regs_model[addr];
    endfunction

    task automatic clear_next();
        nxt_pc      = 32'h0000_1000 + n_rows * 4;
        nxt_stall   = 1'b0;
        nxt_flush   = 1'b0;
        nxt_fwd1    = fwd_none;
        nxt_fwd2    = fwd_none;
        nxt_exe     = '0;
        nxt_wb_addr = '0;
        nxt_wb_data = '0;
        nxt_wb_we   = 1'b0;
    endtask

    task automatic add_row(input logic [2:0] test, input instr_t instr, input instr_class_e cls,
            input alu_op_e op, input logic op1_pc, input logic op2_imm, input word_t imm);
        row_t  r;
        word_t a;
        word_t b;
        r          = '0;
        r.test     = test;
        r.instr    = instr;
        r.pc       = nxt_pc;
        r.stall    = nxt_stall;
        r.flush    = nxt_flush;
        r.fwd1     = nxt_fwd1;
        r.fwd2     = nxt_fwd2;
        r.exe_data = nxt_exe;
        r.wb_addr  = nxt_wb_addr;
        r.wb_data  = nxt_wb_data;
        r.wb_we    = nxt_wb_we;
        a = forwarded(nxt_fwd1, instr[19:15]);
        b = forwarded(nxt_fwd2, instr[24:20]);
        if (nxt_flush) begin
            r.exp = '0;  // Bubble
        end else if (nxt_stall) begin
            r.exp = last_exp;
        end else begin
            r.exp.cls     = cls;
            r.exp.op      = op;
            r.exp.rd      = instr[11:7];
            r.exp.f3      = instr[14:12];
            r.exp.op1     = op1_pc ? nxt_pc : a;
            r.exp.op2     = op2_imm ? imm : b;
            r.exp.lt      = $signed(a) < $signed(b);
            r.exp.ltu     = a < b;
            r.exp.eq      = a == b;
            r.exp.pc      = nxt_pc;
            r.exp.illegal = (cls == cls_none);
        end
        if (nxt_wb_we && nxt_wb_addr != '0) begin  // Seen by reads from the next row on
            regs_model[nxt_wb_addr] = nxt_wb_data;
        end
        last_exp     = r.exp;
        rows[n_rows] = r;
        n_rows++;
        clear_next();
    endtask

    task automatic build_table();
        reg_addr_t wr_list [6];
        wr_list = '{5'd1, 5'd2, 5'd3, 5'd5, 5'd31, 5'd0};
        foreach (wr_list[i]) begin
            nxt_wb_addr = wr_list[i];
            nxt_wb_data = lcg_next();
            nxt_wb_we   = 1'b1;
            add_row(1, nop, cls_alu, alu_add, 1'b0, 1'b1, '0);
        end
        add_row(1, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), cls_alu, alu_add, 1'b0, 1'b0, '0);
        add_row(1, enc_r(7'h00, 5'd5, 5'd3, 3'b000, 5'd4), cls_alu, alu_add, 1'b0, 1'b0, '0);
        add_row(1, enc_r(7'h00, 5'd0, 5'd31, 3'b000, 5'd4), cls_alu, alu_add, 1'b0, 1'b0, '0);
        // One instruction of each kept class
        add_row(2, enc_i(-32'd5, 5'd1, 3'b000, 5'd6, opc_op_imm), cls_alu, alu_add,
            1'b0, 1'b1, -32'd5);
        add_row(2, enc_r(7'h20, 5'd3, 5'd2, 3'b000, 5'd7), cls_alu, alu_sub, 1'b0, 1'b0, '0);
        add_row(2, enc_r(7'h20, 5'd1, 5'd5, 3'b101, 5'd8), cls_alu, alu_sra, 1'b0, 1'b0, '0);
        add_row(2, enc_i(32'd12, 5'd2, 3'b010, 5'd9, opc_load), cls_load, alu_add,
            1'b0, 1'b1, 32'd12);
        add_row(2, enc_s(-32'd20, 5'd3, 5'd1, 3'b010), cls_store, alu_add, 1'b0, 1'b1, -32'd20);
        add_row(2, enc_b(-32'd16, 5'd2, 5'd1, 3'b000), cls_branch, alu_add, 1'b1, 1'b1, -32'd16);
        add_row(2, enc_j(32'h0001_2346, 5'd1), cls_jal, alu_add, 1'b1, 1'b1, 32'h0001_2346);
        add_row(2, enc_i(32'h7ff, 5'd2, 3'b000, 5'd5, opc_jalr), cls_jalr, alu_add,
            1'b0, 1'b1, 32'h7ff);
        add_row(2, enc_u(32'habcd_e000, 5'd10, opc_lui), cls_lui, alu_add,
            1'b0, 1'b1, 32'habcd_e000);
        add_row(2, enc_u(32'h1234_5000, 5'd11, opc_auipc), cls_auipc, alu_add,
            1'b1, 1'b1, 32'h1234_5000);
        // Forwarded sources, the second pair makes lt and ltu differ
        nxt_fwd1 = fwd_exe;
        nxt_exe  = 32'hffff_fff0;
        add_row(3, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd12), cls_alu, alu_add, 1'b0, 1'b0, '0);
        nxt_fwd1    = fwd_wb;
        nxt_fwd2    = fwd_exe;
        nxt_wb_data = 32'h0000_0005;
        nxt_exe     = 32'h8000_0000;
        add_row(3, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd12), cls_alu, alu_add, 1'b0, 1'b0, '0);
        nxt_fwd1    = fwd_exe;
        nxt_fwd2    = fwd_wb;
        nxt_exe     = 32'h8000_0000;
        nxt_wb_data = 32'h0000_0007;
        add_row(3, enc_r(7'h00, 5'd3, 5'd5, 3'b000, 5'd13), cls_alu, alu_add, 1'b0, 1'b0, '0);
        nxt_fwd1    = fwd_wb;
        nxt_fwd2    = fwd_wb;
        nxt_wb_data = 32'h0000_1234;
        add_row(3, enc_r(7'h00, 5'd3, 5'd5, 3'b000, 5'd13), cls_alu, alu_add, 1'b0, 1'b0, '0);
        nxt_fwd1 = fwd_exe;
        nxt_fwd2 = fwd_exe;
        nxt_exe  = 32'h0000_0055;
        add_row(3, enc_b(32'd8, 5'd2, 5'd1, 3'b000), cls_branch, alu_add, 1'b1, 1'b1, 32'd8);
        // Stall holds, flush clears with or without stall
        nxt_stall = 1'b1;
        add_row(4, rows[n_rows-1].instr, cls_none, alu_add, 1'b0, 1'b0, '0);
        add_row(4, enc_i(32'd100, 5'd2, 3'b000, 5'd13, opc_op_imm), cls_alu, alu_add,
            1'b0, 1'b1, 32'd100);
        nxt_flush = 1'b1;
        add_row(4, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), cls_none, alu_add, 1'b0, 1'b0, '0);
        add_row(4, enc_r(7'h20, 5'd3, 5'd2, 3'b000, 5'd7), cls_alu, alu_sub, 1'b0, 1'b0, '0);
        nxt_flush = 1'b1;
        nxt_stall = 1'b1;
        add_row(4, rows[n_rows-1].instr, cls_none, alu_add, 1'b0, 1'b0, '0);
        // Unused opcode, MUL and CSRRW
        add_row(5, 32'h0000_007f, cls_none, alu_add, 1'b0, 1'b0, '0);
        add_row(5, enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), cls_none, alu_add, 1'b0, 1'b0, '0);
        add_row(5, enc_i(32'h300, 5'd2, 3'b001, 5'd1, 5'b11100), cls_none, alu_add,
            1'b0, 1'b0, '0);
    endtask

    task automatic wait_fall(input int limit);
        int t;
        for (t = 0; t < limit; t++) begin
            @(clk_i);
            if (clk_i == 1'b0) break;
        end
        if (t >= limit) begin
            $display("timeout: no falling clock edge after %0d clock changes", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    task automatic drive_row(input row_t r);
        instr_i        = r.instr;
        pc_i           = r.pc;
        stall_i        = r.stall;
        flush_i        = r.flush;
        fwd_sel1_i     = r.fwd1;
        fwd_sel2_i     = r.fwd2;
        exe_fwd_data_i = r.exe_data;
        wb_addr_i      = r.wb_addr;
        wb_data_i      = r.wb_data;
        wb_we_i        = r.wb_we;
    endtask

    task automatic log_mismatch(input logic [2:0] test, input string name,
            input logic [31:0] got, input logic [31:0] exp);
        $display("error: %s is 0x%h, expected 0x%h (%s)", name, got, exp, test_names[test]);
        errors[test]++;
    endtask

    task automatic check_row(input row_t r);
        checks++;
        // Source addresses follow the instruction that is still applied
        assert (rs1_addr_o == r.instr[19:15])
            else log_mismatch(r.test, "rs1_addr_o", rs1_addr_o, r.instr[19:15]);
        assert (rs2_addr_o == r.instr[24:20])
            else log_mismatch(r.test, "rs2_addr_o", rs2_addr_o, r.instr[24:20]);
        assert (exe_class_o == r.exp.cls)
            else log_mismatch(r.test, "exe_class_o", exe_class_o, r.exp.cls);
        assert (exe_alu_op_o == r.exp.op)
            else log_mismatch(r.test, "exe_alu_op_o", exe_alu_op_o, r.exp.op);
        assert (exe_rd_addr_o == r.exp.rd)
            else log_mismatch(r.test, "exe_rd_addr_o", exe_rd_addr_o, r.exp.rd);
        assert (exe_funct3_o == r.exp.f3)
            else log_mismatch(r.test, "exe_funct3_o", exe_funct3_o, r.exp.f3);
        assert (exe_op1_o == r.exp.op1)
            else log_mismatch(r.test, "exe_op1_o", exe_op1_o, r.exp.op1);
        assert (exe_op2_o == r.exp.op2)
            else log_mismatch(r.test, "exe_op2_o", exe_op2_o, r.exp.op2);
        assert (exe_lt_o == r.exp.lt)
            else log_mismatch(r.test, "exe_lt_o", exe_lt_o, r.exp.lt);
        assert (exe_ltu_o == r.exp.ltu)
            else log_mismatch(r.test, "exe_ltu_o", exe_ltu_o, r.exp.ltu);
        assert (exe_eq_o == r.exp.eq)
            else log_mismatch(r.test, "exe_eq_o", exe_eq_o, r.exp.eq);
        assert (exe_pc_o == r.exp.pc)
            else log_mismatch(r.test, "exe_pc_o", exe_pc_o, r.exp.pc);
        assert (exe_illegal_o == r.exp.illegal)
            else log_mismatch(r.test, "exe_illegal_o", exe_illegal_o, r.exp.illegal);
    endtask

    task automatic report_test(input logic [2:0] test);
        if (errors[test] == 0) begin
            $display("test %-16s ok", test_names[test]);
        end else begin
            $display("test %-16s failed with %0d errors", test_names[test], errors[test]);
        end
    endtask

    initial begin
        row_t reset_row;
        int   fails;
        clk_i          = 1'b0;
        arst_n_i       = 1'b0;
        instr_i        = nop;
        pc_i           = '0;
        stall_i        = 1'b0;
        flush_i        = 1'b0;
        fwd_sel1_i     = fwd_none;
        fwd_sel2_i     = fwd_none;
        exe_fwd_data_i = '0;
        wb_addr_i      = '0;
        wb_data_i      = '0;
        wb_we_i        = 1'b0;
        test_names = '{"reset", "register file", "decode", "forwarding", "stall and flush",
            "illegal"};
        lcg_state = 32'd62561;
        n_rows    = 0;
        checks    = 0;
        reset_row = '0;
        reset_row.instr = nop;
        foreach (regs_model[i]) regs_model[i] = '0;
        foreach (errors[i]) errors[i] = 0;
        clear_next();
        build_table();
        repeat (5) wait_fall(4);
        check_row(reset_row);  // Still in reset here
        report_test(0);
        arst_n_i = 1'b1;
        for (int i = 0; i <= n_rows; i++) begin
            if (i > 0) begin
                wait_fall(4);
                check_row(rows[i-1]);  // Captured on the rising edge just passed
                if (i == n_rows || rows[i].test != rows[i-1].test) begin
                    report_test(rows[i-1].test);
                end
            end
            if (i < n_rows) begin
                drive_row(rows[i]);
            end
        end
        fails = 0;
        foreach (errors[i]) fails += errors[i];
        $display("%0d rows checked, %0d errors", checks, fails);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
